//--- hdl/sram_controller.sv
//////////////////////////////////////////////////////////////////////
// Slot-based SRAM controller.
// Runs fixed six-cycle slots, drives address, write enable and the
// tristate data bus, and samples read data mid-slot.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sram_ctrl_settings.svh"

module sram_controller
    import sram_types_pkg::*;
    import sram_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    sram_req_if.ctrl   req,
    output sram_addr_t sram_address,
    output logic       sram_we_n,
    inout  sram_data_t sram_data,
    output sram_data_t read_data,
    output logic       read_done,
    output logic       active
);

    localparam slot_step_t LAST_STEP   = slot_step_t'(`SRAM_SLOT_LEN - 1);
    localparam slot_step_t WE_ON       = slot_step_t'(`SRAM_WE_ON_STEP);
    localparam slot_step_t WE_OFF      = slot_step_t'(`SRAM_WE_OFF_STEP);
    localparam slot_step_t DATA_ON     = slot_step_t'(`SRAM_DATA_ON_STEP);
    localparam slot_step_t DATA_OFF    = slot_step_t'(`SRAM_DATA_OFF_STEP);
    localparam slot_step_t SAMPLE_STEP = slot_step_t'(`SRAM_SAMPLE_STEP);

    slot_step_t  step;
    sram_state_t state;
    sram_addr_t  addr_buf;
    sram_data_t  wdata_buf;
    sram_data_t  rdata_buf;
    logic        slot_end;
    logic        we_active;
    logic        data_oe;
    logic        sample;

    assign slot_end = (step == LAST_STEP);

    // Accept the held request only at the slot boundary.
    assign req.take = req.pending && slot_end;

    // Step counter runs freely, state changes once per slot.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            step  <= '0;
            state <= IDLE;
        end else if (slot_end) begin
            step <= '0;
            if (req.take) begin
                state <= req.is_read ? READ : WRITE;
            end else begin
                state <= IDLE;
            end
        end else begin
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.take) begin
            addr_buf  <= req.address;
            wdata_buf <= req.wdata;
        end
    end

    assign we_active = (state == WRITE) && (step >= WE_ON) && (step < WE_OFF);
    assign data_oe   = (state == WRITE) && (step >= DATA_ON) && (step < DATA_OFF);
    assign sample    = (state == READ) && (step == SAMPLE_STEP);

    assign sram_address = addr_buf;
    assign sram_we_n    = !we_active;
    assign sram_data    = data_oe ? wdata_buf : 'z;

    // Capture the chip output in the middle of a read slot.
    always_ff @(posedge clk) begin
        if (sample) begin
            rdata_buf <= sram_data;
        end
    end

    // Completion pulse lands on the step after sampling.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            read_done <= 1'b0;
        end else begin
            read_done <= sample;
        end
    end

    assign read_data = rdata_buf;
    assign active    = (state != IDLE);

    // Chip output must have been off for two cycles before we drive.
    a_no_bus_contention: assert property (
        @(posedge clk) disable iff (!rstn)
        data_oe |-> (!sram_we_n && $past(!sram_we_n, 2))
    ) else $error("data bus driven too soon after write enable");

    // Write enable only falls at the start of a slot that took a write.
    a_we_only_in_write: assert property (
        @(posedge clk) disable iff (!rstn)
        $fell(sram_we_n) |-> $past(req.take && !req.is_read)
    ) else $error("write enable fell outside a taken write slot");

endmodule

//--- hdl/sram_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// SRAM controller FSM states.
//////////////////////////////////////////////////////////////////////

package sram_ctrl_pkg;

    // What the controller does during the current slot.
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } sram_state_t;

endpackage

//--- hdl/sram_req_hold.sv
//////////////////////////////////////////////////////////////////////
// SRAM request holder.
// Latches a one-cycle user request and keeps it until the controller
// takes it at a slot boundary.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_req_hold import sram_types_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       req_read,
    input  logic       req_write,
    input  sram_addr_t req_address,
    input  sram_data_t req_data,
    sram_req_if.holder req
);

    logic accept;

    // New pulses only count while nothing is held.
    assign accept = !req.pending && (req_read || req_write);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req.pending <= 1'b0;
            req.is_read <= 1'b0;
        end else if (req.take) begin
            req.pending <= 1'b0;
        end else if (accept) begin
            req.pending <= 1'b1;
            // Read wins when both pulses arrive together.
            req.is_read <= req_read;
        end
    end

    // Payload follows the accepted pulse.
    always_ff @(posedge clk) begin
        if (accept) begin
            req.address <= req_address;
            req.wdata   <= req_data;
        end
    end

    // The controller only takes what is actually held.
    a_take_needs_pending: assert property (
        @(posedge clk) disable iff (!rstn)
        req.take |-> req.pending
    ) else $error("take asserted with no pending request");

endmodule

//--- hdl/sram_req_if.sv
//////////////////////////////////////////////////////////////////////
// Pending request link.
// Carries one held request from the holder to the controller.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface sram_req_if import sram_types_pkg::*; ();

    logic       pending;
    logic       is_read;
    sram_addr_t address;
    sram_data_t wdata;
    // Controller accepts the request at the end of a slot.
    logic       take;

    modport holder (
        output pending,
        output is_read,
        output address,
        output wdata,
        input  take
    );

    modport ctrl (
        input  pending,
        input  is_read,
        input  address,
        input  wdata,
        output take
    );

endinterface

//--- hdl/sram_subsystem.sv
//////////////////////////////////////////////////////////////////////
// SRAM subsystem top.
// Request holder plus slot controller, with user and SRAM pins.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_subsystem import sram_types_pkg::*; (
    input  logic       clk,
    input  logic       rstn,

    // User side.
    input  logic       req_read,
    input  logic       req_write,
    input  sram_addr_t req_address,
    input  sram_data_t req_data,
    output logic       busy,
    output sram_data_t read_data,
    output logic       read_done,

    // SRAM chip pins.
    output sram_addr_t sram_address,
    output logic       sram_we_n,
    inout  sram_data_t sram_data
);

    logic ctrl_active;

    sram_req_if req_bus ();

    sram_req_hold i_sram_req_hold (
        .clk         (clk),
        .rstn        (rstn),
        .req_read    (req_read),
        .req_write   (req_write),
        .req_address (req_address),
        .req_data    (req_data),
        .req         (req_bus.holder)
    );

    sram_controller i_sram_controller (
        .clk          (clk),
        .rstn         (rstn),
        .req          (req_bus.ctrl),
        .sram_address (sram_address),
        .sram_we_n    (sram_we_n),
        .sram_data    (sram_data),
        .read_data    (read_data),
        .read_done    (read_done),
        .active       (ctrl_active)
    );

    // Busy covers both the wait for a slot and the slot itself.
    assign busy = req_bus.pending || ctrl_active;

endmodule

//--- hdl/sram_types_pkg.sv
//////////////////////////////////////////////////////////////////////
// SRAM vector types.
// Address, data word and slot step counter.
//////////////////////////////////////////////////////////////////////

`include "sram_ctrl_settings.svh"

package sram_types_pkg;

    // Address on the SRAM pins.
    typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

    // One data word.
    typedef logic [`SRAM_DATA_W-1:0] sram_data_t;

    // Step within a transaction slot.
    typedef logic [$clog2(`SRAM_SLOT_LEN)-1:0] slot_step_t;

endpackage

//--- include/sram_ctrl_settings.svh
//////////////////////////////////////////////////////////////////////
// SRAM controller settings.
// Bus widths, slot length and the step numbers inside one slot.
//////////////////////////////////////////////////////////////////////

`ifndef SRAM_CTRL_SETTINGS_SVH
`define SRAM_CTRL_SETTINGS_SVH

`define SRAM_ADDR_W 5
`define SRAM_DATA_W 8

// Cycles in one transaction slot.
`define SRAM_SLOT_LEN 6

// Data goes on the bus two steps after write enable falls.
// This keeps the chip's output driver and ours apart.
`define SRAM_WE_ON_STEP    0
`define SRAM_DATA_ON_STEP  2
`define SRAM_WE_OFF_STEP   5
`define SRAM_DATA_OFF_STEP 5
`define SRAM_SAMPLE_STEP   3

`endif

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_sram_subsystem -f sram_subsystem.f -o tb_sram_subsystem \
    && ./obj_dir/tb_sram_subsystem | tee /dev/stderr | grep -qx "Test OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sram_subsystem.f
+incdir+include
hdl/sram_types_pkg.sv
hdl/sram_ctrl_pkg.sv
hdl/sram_req_if.sv
hdl/sram_req_hold.sv
hdl/sram_controller.sv
hdl/sram_subsystem.sv
verif/sram_model.sv
verif/tb_sram_subsystem.sv

//--- verif/sram_model.sv
//////////////////////////////////////////////////////////////////////
// Behavioural asynchronous SRAM.
// Writes on the rising edge of write enable, drives the bus otherwise.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sram_ctrl_settings.svh"

module sram_model import sram_types_pkg::*; (
    input  sram_addr_t sram_address,
    input  logic       sram_we_n,
    inout  sram_data_t sram_data
);

    localparam int DEPTH = 1 << `SRAM_ADDR_W;

    sram_data_t mem [0:DEPTH-1];
    sram_data_t bus_late;

    // Power-up contents, different for every address.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = sram_data_t'(i * 37 + 11);
        end
    end

    // Bus as it was just before the latest change.
    // The controller releases the bus on the edge that raises write enable.
    assign #1 bus_late = sram_data;

    always @(posedge sram_we_n) begin
        mem[sram_address] = bus_late;
    end

    // Output driver is on whenever no write is in progress.
    assign sram_data = sram_we_n ? mem[sram_address] : 'z;

endmodule

//--- verif/tb_sram_subsystem.sv
//////////////////////////////////////////////////////////////////////
// SRAM subsystem testbench.
// Random reads and writes checked against a shadow memory, with
// monitors on the data bus, busy and read completion.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sram_ctrl_settings.svh"

module tb_sram_subsystem import sram_types_pkg::*; ();

    localparam int CLK_HALF_NS = 4;
    localparam int CLK_NS      = 2 * CLK_HALF_NS;
    localparam int DEPTH       = 1 << `SRAM_ADDR_W;
    localparam int RANDOM_OPS  = 150;
    // Single write and read, address fill, random mix, dual pulse pair.
    localparam int TOTAL_OPS   = 2 + DEPTH + RANDOM_OPS + 2;
    // A request needs at most three slots, counting the wait for a boundary.
    localparam int WATCHDOG_NS = TOTAL_OPS * 3 * `SRAM_SLOT_LEN * CLK_NS + 16 * CLK_NS + 2000;

    logic       clk = 1'b0;
    logic       rstn;
    logic       req_read;
    logic       req_write;
    sram_addr_t req_address;
    sram_data_t req_data;
    logic       busy;
    sram_data_t read_data;
    logic       read_done;
    sram_addr_t sram_address;
    logic       sram_we_n;
    wire [`SRAM_DATA_W-1:0] sram_data;

    logic [31:0] lfsr;
    sram_data_t  shadow [0:DEPTH-1];
    sram_addr_t  exp_addr_q [$];
    sram_data_t  exp_data_q [$];
    logic        pulse_seen = 1'b0;
    int          errors;
    int          checks;
    int          reads_issued;
    int          writes_issued;
    int          reads_done;

    always #CLK_HALF_NS clk = ~clk;

    sram_subsystem i_sram_subsystem (
        .clk          (clk),
        .rstn         (rstn),
        .req_read     (req_read),
        .req_write    (req_write),
        .req_address  (req_address),
        .req_data     (req_data),
        .busy         (busy),
        .read_data    (read_data),
        .read_done    (read_done),
        .sram_address (sram_address),
        .sram_we_n    (sram_we_n),
        .sram_data    (sram_data)
    );

    sram_model i_sram_model (
        .sram_address (sram_address),
        .sram_we_n    (sram_we_n),
        .sram_data    (sram_data)
    );

    // Galois form, polynomial x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // A read returns the last word written to that address.
    function automatic sram_data_t expected_read(input sram_addr_t addr);
        return shadow[addr];
    endfunction

    task automatic wait_idle();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // One-cycle request pulse, sent only while the subsystem is idle.
    task automatic send_request(input logic rd, input logic wr,
                                input sram_addr_t addr, input sram_data_t data);
        wait_idle();
        @(posedge clk);
        req_read    <= rd;
        req_write   <= wr;
        req_address <= addr;
        req_data    <= data;
        @(posedge clk);
        req_read  <= 1'b0;
        req_write <= 1'b0;
    endtask

    task automatic do_write(input sram_addr_t addr, input sram_data_t data);
        send_request(1'b0, 1'b1, addr, data);
        shadow[addr] = data;
        writes_issued++;
    endtask

    task automatic do_read(input sram_addr_t addr);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(expected_read(addr));
        send_request(1'b1, 1'b0, addr, '0);
        reads_issued++;
    endtask

    // Every read must have completed once the subsystem goes idle.
    task automatic drain();
        wait_idle();
        @(negedge clk);
        if (exp_data_q.size() != 0) begin
            $display("%0d read(s) at %0t ns ended without a read_done pulse",
                     exp_data_q.size(), $time);
            errors++;
            exp_addr_q.delete();
            exp_data_q.delete();
        end
    endtask

    task automatic check_idle_outputs();
        checks++;
        if (sram_we_n !== 1'b1) begin
            $display("Error at %0t: sram_we_n is %b, expected 1", $time, sram_we_n);
            errors++;
        end
        if (busy !== 1'b0) begin
            $display("Error at %0t: busy is %b, expected 0", $time, busy);
            errors++;
        end
        if (read_done !== 1'b0) begin
            $display("Error at %0t: read_done is %b, expected 0", $time, read_done);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %0d errors", name, errors - errors_before);
    endtask

    // Read results, in issue order.
    always @(negedge clk) begin
        sram_addr_t addr;
        sram_data_t want;
        if (rstn && read_done) begin
            if (exp_data_q.size() == 0) begin
                $display("read_done pulsed at %0t ns with no read outstanding", $time);
                errors++;
            end else begin
                addr = exp_addr_q.pop_front();
                want = exp_data_q.pop_front();
                checks++;
                reads_done++;
                // The read address is still on the pins at the completion step.
                if (sram_address !== addr) begin
                    $display("Error at %0t: read of address %0d drove sram_address %0d",
                             $time, addr, sram_address);
                    errors++;
                end
                if (read_data !== want) begin
                    $display("Error at %0t: read of address %0d returned %02h, expected %02h",
                             $time, addr, read_data, want);
                    errors++;
                end
            end
        end
    end

    // With write enable high only the SRAM may drive the bus.
    always @(negedge clk) begin
        if (rstn && sram_we_n && sram_data !== i_sram_model.mem[sram_address]) begin
            $display("Error at %0t: bus shows %02h while the SRAM drives %02h",
                     $time, sram_data, i_sram_model.mem[sram_address]);
            errors++;
        end
    end

    always @(posedge clk) begin
        pulse_seen <= req_read || req_write;
    end

    always @(negedge clk) begin
        if (rstn && pulse_seen && !busy) begin
            $display("Error at %0t: request pulse did not raise busy", $time);
            errors++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the subsystem stopped making progress", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int         mark;
        sram_addr_t addr;
        sram_data_t data;

        rstn          = 1'b0;
        req_read      = 1'b0;
        req_write     = 1'b0;
        req_address   = '0;
        req_data      = '0;
        lfsr          = 32'hef919348;
        errors        = 0;
        checks        = 0;
        reads_issued  = 0;
        writes_issued = 0;
        reads_done    = 0;

        // Reset for 16 cycles, checked once inside and once after.
        mark = errors;
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_idle_outputs();
        report_test("reset values", mark);

        mark = errors;
        addr = sram_addr_t'(random_bits(`SRAM_ADDR_W));
        data = sram_data_t'(random_bits(`SRAM_DATA_W));
        do_write(addr, data);
        do_read(addr);
        drain();
        report_test("single write then read", mark);

        mark = errors;
        for (int a = 0; a < DEPTH; a++) begin
            do_write(sram_addr_t'(a), sram_data_t'(random_bits(`SRAM_DATA_W)));
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            addr = sram_addr_t'(random_bits(`SRAM_ADDR_W));
            if (random_bits(1) == 32'd1) begin
                do_read(addr);
            end else begin
                do_write(addr, sram_data_t'(random_bits(`SRAM_DATA_W)));
            end
        end
        drain();
        report_test("random reads and writes", mark);

        // Both pulses at once must read and leave the word alone.
        mark = errors;
        addr = sram_addr_t'(random_bits(`SRAM_ADDR_W));
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(expected_read(addr));
        send_request(1'b1, 1'b1, addr, ~expected_read(addr));
        reads_issued++;
        do_read(addr);
        drain();
        report_test("read and write pulsed together", mark);

        $display("checks %0d, writes %0d, reads %0d, read_done %0d, errors %0d",
                 checks, writes_issued, reads_issued, reads_done, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
